/* simpleCore.f */
+incdir+.
simplePkg.sv
decodeUnit.sv
registerFile.sv
alu.sv
executePipeline.sv
simpleCore.sv
tb_simpleCore.sv

/* Bender.yml */
package:
  name: simple_core

sources:
  - include_dirs:
      - .
    files:
      - simplePkg.sv
      - decodeUnit.sv
      - registerFile.sv
      - alu.sv
      - executePipeline.sv
      - simpleCore.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_simpleCore.sv

/* tb_simpleCore.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module tb_simpleCore;
   import simplePkg::*;

   localparam int Dw          = `SIMPLE_DATA_W;
   localparam int ResetCycles = 16;
   localparam int MaxEntries  = 320;
   localparam int MaxTests    = 8;
   // function codes that have no ALU opcode of their own
   localparam logic [3:0] FnCmp = 4'b0101;
   localparam logic [3:0] FnMov = 4'b0110;
   localparam logic [3:0] FnIn  = 4'b1100;
   localparam logic [3:0] FnOut = 4'b1101;

   logic          clk;
   logic          rstN;
   logic [Dw-1:0] instr;
   logic          instrValid;
   logic [Dw-1:0] inData;
   logic          outValid;
   logic [Dw-1:0] outData;

   // one row per issue cycle
   logic [Dw-1:0] tblCmd [MaxEntries];
   logic          tblValid [MaxEntries];
   logic [Dw-1:0] tblIn [MaxEntries];
   logic          tblExpOut [MaxEntries];
   logic [Dw-1:0] tblExpData [MaxEntries];
   int            tblTest [MaxEntries];
   string         testNames [MaxTests];
   int            testChecks [MaxTests];
   int            testErrors [MaxTests];
   logic [Dw-1:0] model [`SIMPLE_REG_N];
   int            nEntries = 0;
   int            nTests = 0;
   int            seed;
   int            cycleCount = 0;
   int            cycleLimit = MaxEntries + ResetCycles + 20;
   int            totalChecks = 0;
   int            totalErrors = 0;

   simpleCore uut (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .instrValid (instrValid),
      .inData     (inData),
      .outValid   (outValid),
      .outData    (outData)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("timeout after %0d cycles, the run did not finish", cycleCount);
         $display("sim failed");
         $finish;
      end
   end

   function automatic logic [Dw-1:0] randWord();
      logic [31:0] r;
      r = $random(seed);
      return r[Dw-1:0];
   endfunction

   function automatic logic [7:0] randByte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic logic [Dw-1:0] aluCmd(input logic [3:0] fn, input int rd, input int rs,
                                            input int sh);
      return {grpAlu, rs[2:0], rd[2:0], fn, sh[3:0]};
   endfunction

   function automatic logic [Dw-1:0] liCmd(input int rd, input logic [7:0] imm);
      return {grpImm, 3'b000, rd[2:0], imm};
   endfunction

   // register model, program order, Rd op Rs
   function automatic void modelStep(input logic [Dw-1:0] cmd, input logic [Dw-1:0] inVal);
      logic [Dw-1:0] rd;
      logic [Dw-1:0] rs;
      logic [Dw-1:0] res;
      logic          wr;
      int            sh;
      rd = model[cmd[10:8]];
      rs = model[cmd[13:11]];
      sh = cmd[3:0];
      res = '0;
      wr = 1'b1;
      if (instrGroupE'(cmd[15:14]) == grpImm && cmd[13:11] == 3'b000) begin
         res = {{(Dw-8){cmd[7]}}, cmd[7:0]};
      end else if (instrGroupE'(cmd[15:14]) != grpAlu) begin
         wr = 1'b0;
      end else begin
         case (cmd[7:4])
            aluAdd: res = rd + rs;
            aluSub: res = rd - rs;
            aluAnd: res = rd & rs;
            aluOr:  res = rd | rs;
            aluXor: res = rd ^ rs;
            FnMov:  res = rs;
            aluSll: res = rd << sh;
            aluSlr: res = (rd << sh) | (rd >> (Dw - sh));
            aluSrl: res = rd >> sh;
            aluSra: res = (rd >> sh) | (rd[Dw-1] ? ~({Dw{1'b1}} >> sh) : '0);
            FnIn:   res = inVal;
            default: wr = 1'b0;
         endcase
      end
      if (wr)
         model[cmd[10:8]] = res;
   endfunction

   task automatic startTest(input string name);
      testNames[nTests] = name;
      testChecks[nTests] = 0;
      testErrors[nTests] = 0;
      nTests++;
   endtask

   task automatic addEntry(input logic [Dw-1:0] cmd, input logic valid,
                           input logic [Dw-1:0] inVal);
      tblCmd[nEntries] = cmd;
      tblValid[nEntries] = valid;
      tblIn[nEntries] = inVal;
      tblTest[nEntries] = nTests - 1;
      tblExpOut[nEntries] = valid && cmd[15:14] == grpAlu && cmd[7:4] == FnOut;
      tblExpData[nEntries] = model[cmd[13:11]];
      if (valid)
         modelStep(cmd, inVal);
      nEntries++;
   endtask

   task automatic issue(input logic [Dw-1:0] cmd);
      addEntry(cmd, 1'b1, randWord());
   endtask

   // idle issue port carrying a random command
   task automatic bubble();
      addEntry(randWord(), 1'b0, randWord());
   endtask

   task automatic buildTable();
      logic [3:0] fns [7];
      logic [3:0] shiftFns [4];
      int         shAmts [4];
      int         rd;
      int         rs;
      logic [7:0] b;
      fns = '{aluAdd, aluSub, aluAnd, aluOr, aluXor, FnMov, FnCmp};
      shiftFns = '{aluSll, aluSlr, aluSrl, aluSra};
      shAmts = '{0, 1, 7, 15};
      for (int r = 0; r < `SIMPLE_REG_N; r++)
         model[r] = '0;
      startTest("idle");
      repeat (6) bubble();
      startTest("resetZero");
      for (int r = 0; r < `SIMPLE_REG_N; r++)
         issue(aluCmd(FnOut, 0, r, 0));
      startTest("loadImm");
      for (int r = 0; r < `SIMPLE_REG_N; r += 2) begin
         b = randByte();
         issue(liCmd(r, {1'b0, b[6:0]}));
         issue(liCmd(r + 1, {1'b1, b[6:0]}));
         issue(aluCmd(FnOut, 0, r, 0));
         issue(aluCmd(FnOut, 0, r + 1, 0));
      end
      startTest("aluOps");
      for (int rep = 0; rep < 2; rep++) begin
         foreach (fns[i]) begin
            rd = randWord() % `SIMPLE_REG_N;
            rs = randWord() % `SIMPLE_REG_N;
            issue(liCmd(rd, randByte()));
            issue(liCmd(rs, randByte()));
            // second pass reads operands from the register file
            if (rep == 1)
               repeat (2) bubble();
            issue(aluCmd(fns[i], rd, rs, 0));
            issue(aluCmd(FnOut, 0, rd, 0));
         end
      end
      startTest("shifts");
      foreach (shiftFns[i]) begin
         foreach (shAmts[j]) begin
            for (int top = 0; top < 2; top++) begin
               b = randByte();
               issue(liCmd(3, {top[0], b[6:0]}));
               issue(aluCmd(shiftFns[i], 3, 0, shAmts[j]));
               issue(aluCmd(FnOut, 0, 3, 0));
            end
         end
      end
      startTest("forwarding");
      issue(liCmd(4, randByte()));
      issue(liCmd(5, randByte()));
      // Rd from write-back, Rs from execute
      issue(aluCmd(aluAdd, 4, 5, 0));
      issue(aluCmd(FnOut, 0, 4, 0));
      issue(aluCmd(aluSub, 5, 4, 0));
      issue(aluCmd(FnOut, 0, 5, 0));
      // both earlier writers hit r6, newer wins
      issue(liCmd(6, randByte()));
      issue(liCmd(6, randByte()));
      issue(aluCmd(aluXor, 6, 4, 0));
      issue(aluCmd(FnOut, 0, 6, 0));
      issue(liCmd(7, randByte()));
      issue(liCmd(7, randByte()));
      issue(aluCmd(aluOr, 2, 7, 0));
      issue(aluCmd(FnOut, 0, 2, 0));
      issue(aluCmd(aluAdd, 1, 1, 0));
      issue(aluCmd(aluAdd, 1, 1, 0));
      issue(aluCmd(FnOut, 0, 1, 0));
      startTest("inOutBubbles");
      addEntry(aluCmd(FnIn, 2, 0, 0), 1'b1, randWord());
      issue(aluCmd(FnOut, 0, 2, 0));
      addEntry(aluCmd(FnIn, 3, 0, 0), 1'b1, randWord());
      repeat (2) bubble();
      issue(aluCmd(FnOut, 0, 3, 0));
      bubble();
      issue(liCmd(0, randByte()));
      bubble();
      issue(aluCmd(aluAdd, 0, 3, 0));
      bubble();
      issue(aluCmd(FnOut, 0, 0, 0));
      repeat (2) bubble();
   endtask

   task automatic reportTest(input int t);
      if (testErrors[t] == 0)
         $display("%-14s ok, %0d cycles checked", testNames[t], testChecks[t]);
      else
         $display("%-14s FAILED, %0d errors", testNames[t], testErrors[t]);
   endtask

   // outputs of the entry issued two cycles earlier
   task automatic checkOutputs(input int k);
      int t;
      if (k < 0) begin
         assert (!outValid) else begin
            $display("outValid raised right after reset with nothing issued");
            totalErrors++;
         end
         return;
      end
      t = tblTest[k];
      testChecks[t]++;
      totalChecks++;
      if (tblExpOut[k]) begin
         assert (outValid) else begin
            $display("test %s: OUT at entry %0d never raised outValid", testNames[t], k);
            testErrors[t]++;
            totalErrors++;
         end
         if (outValid) begin
            assert (outData === tblExpData[k]) else begin
               $display("Mismatch %s: expected %h, actual %h", testNames[t], tblExpData[k],
                        outData);
               testErrors[t]++;
               totalErrors++;
            end
         end
      end else begin
         assert (!outValid) else begin
            $display("test %s: outValid high with no OUT pending at entry %0d",
                     testNames[t], k);
            testErrors[t]++;
            totalErrors++;
         end
      end
      if (k == nEntries - 1 || tblTest[k+1] != t)
         reportTest(t);
   endtask

   initial begin
      seed = 46677;
      rstN = 1'b0;
      instr = `SIMPLE_NOP;
      instrValid = 1'b0;
      inData = '0;
      buildTable();
      cycleLimit = nEntries + ResetCycles + 20;
      repeat (ResetCycles) @(posedge clk);
      for (int n = 0; n < nEntries + 2; n++) begin
         @(negedge clk);
         rstN = 1'b1;
         checkOutputs(n - 2);
         if (n < nEntries) begin
            instr = tblCmd[n];
            instrValid = tblValid[n];
            inData = tblIn[n];
         end else begin
            instr = `SIMPLE_NOP;
            instrValid = 1'b0;
         end
      end
      $display("%0d tests, %0d checks, %0d errors", nTests, totalChecks, totalErrors);
      if (totalErrors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* simpleCore.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module simpleCore (
   input  logic                      clk,
   input  logic                      rstN,
   input  logic [`SIMPLE_DATA_W-1:0] instr,
   input  logic                      instrValid,
   input  logic [`SIMPLE_DATA_W-1:0] inData,
   output logic                      outValid,
   output logic [`SIMPLE_DATA_W-1:0] outData
);
   import simplePkg::*;

   aluOpE                      aluOp;
   logic [`SIMPLE_RADDR_W-1:0] writeAddress;
   logic                       regWrite;
   logic                       immSel;
   logic                       inSel;
   logic                       outEn;
   logic                       oneA;
   logic                       oneB;
   logic                       twoA;
   logic                       twoB;
   logic [`SIMPLE_DATA_W-1:0]  readDataA;
   logic [`SIMPLE_DATA_W-1:0]  readDataB;
   logic [`SIMPLE_DATA_W-1:0]  beforeCommand;
   logic [`SIMPLE_DATA_W-1:0]  twoBeforeCommand;
   logic                       writeEn;
   logic [`SIMPLE_RADDR_W-1:0] writeAddr;
   logic [`SIMPLE_DATA_W-1:0]  writeData;

   decodeUnit uDecode (
      .command          (instr),
      .beforeCommand    (beforeCommand),
      .twoBeforeCommand (twoBeforeCommand),
      .aluOp            (aluOp),
      .writeAddress     (writeAddress),
      .regWrite         (regWrite),
      .immSel           (immSel),
      .inSel            (inSel),
      .outEn            (outEn),
      .oneA             (oneA),
      .oneB             (oneB),
      .twoA             (twoA),
      .twoB             (twoB)
   );

   // port A reads Rd, port B reads Rs
   registerFile uRegs (
      .clk       (clk),
      .rstN      (rstN),
      .readAddrA (instr[10:8]),
      .readAddrB (instr[13:11]),
      .writeAddr (writeAddr),
      .writeEn   (writeEn),
      .writeData (writeData),
      .readDataA (readDataA),
      .readDataB (readDataB)
   );

   executePipeline uPipe (
      .clk              (clk),
      .rstN             (rstN),
      .command          (instr),
      .instrValid       (instrValid),
      .aluOp            (aluOp),
      .writeAddress     (writeAddress),
      .regWrite         (regWrite),
      .immSel           (immSel),
      .inSel            (inSel),
      .outEn            (outEn),
      .oneA             (oneA),
      .oneB             (oneB),
      .twoA             (twoA),
      .twoB             (twoB),
      .readDataA        (readDataA),
      .readDataB        (readDataB),
      .inData           (inData),
      .beforeCommand    (beforeCommand),
      .twoBeforeCommand (twoBeforeCommand),
      .writeEn          (writeEn),
      .writeAddr        (writeAddr),
      .writeData        (writeData),
      .outValid         (outValid),
      .outData          (outData)
   );

endmodule

/* executePipeline.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module executePipeline (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`SIMPLE_DATA_W-1:0]  command,
   input  logic                       instrValid,
   input  simplePkg::aluOpE           aluOp,
   input  logic [`SIMPLE_RADDR_W-1:0] writeAddress,
   input  logic                       regWrite,
   input  logic                       immSel,
   input  logic                       inSel,
   input  logic                       outEn,
   input  logic                       oneA,
   input  logic                       oneB,
   input  logic                       twoA,
   input  logic                       twoB,
   input  logic [`SIMPLE_DATA_W-1:0]  readDataA,
   input  logic [`SIMPLE_DATA_W-1:0]  readDataB,
   input  logic [`SIMPLE_DATA_W-1:0]  inData,
   output logic [`SIMPLE_DATA_W-1:0]  beforeCommand,
   output logic [`SIMPLE_DATA_W-1:0]  twoBeforeCommand,
   output logic                       writeEn,
   output logic [`SIMPLE_RADDR_W-1:0] writeAddr,
   output logic [`SIMPLE_DATA_W-1:0]  writeData,
   output logic                       outValid,
   output logic [`SIMPLE_DATA_W-1:0]  outData
);
   import simplePkg::*;

   localparam int ShiftW = $clog2(`SIMPLE_DATA_W);

   logic [`SIMPLE_DATA_W-1:0]  opA;
   logic [`SIMPLE_DATA_W-1:0]  opB;
   logic [`SIMPLE_DATA_W-1:0]  regOpB;
   logic [`SIMPLE_DATA_W-1:0]  exOpA;
   logic [`SIMPLE_DATA_W-1:0]  exOpB;
   logic [ShiftW-1:0]          exShiftAmt;
   aluOpE                      exAluOp;
   logic [`SIMPLE_RADDR_W-1:0] exWriteAddr;
   logic                       exRegWrite;
   logic                       exOutEn;
   logic [`SIMPLE_DATA_W-1:0]  aluResult;
   logic [`SIMPLE_DATA_W-1:0]  wbResult;

   // execute result first, then write-back, then register file
   assign opA    = oneA ? aluResult : (twoA ? wbResult : readDataA);
   assign regOpB = oneB ? aluResult : (twoB ? wbResult : readDataB);

   always_comb begin
      if (immSel)
         opB = {{(`SIMPLE_DATA_W-8){command[7]}}, command[7:0]};
      else if (inSel)
         opB = inData;
      else
         opB = regOpB;
   end

   // an idle issue port enters the execute stage as a bubble
   always_ff @(posedge clk) begin
      if (!rstN) begin
         beforeCommand <= `SIMPLE_NOP;
         exRegWrite    <= 1'b0;
         exOutEn       <= 1'b0;
         exAluOp       <= aluNon;
      end else begin
         beforeCommand <= instrValid ? command : `SIMPLE_NOP;
         exRegWrite    <= instrValid & regWrite;
         exOutEn       <= instrValid & outEn;
         exAluOp       <= aluOp;
      end
   end

   always_ff @(posedge clk) begin
      exOpA       <= opA;
      exOpB       <= opB;
      exShiftAmt  <= command[ShiftW-1:0];
      exWriteAddr <= writeAddress;
   end

   alu uAlu (
      .opA      (exOpA),
      .opB      (exOpB),
      .shiftAmt (exShiftAmt),
      .op       (exAluOp),
      .result   (aluResult)
   );

   // write-back stage
   always_ff @(posedge clk) begin
      if (!rstN) begin
         twoBeforeCommand <= `SIMPLE_NOP;
         writeEn          <= 1'b0;
         outValid         <= 1'b0;
      end else begin
         twoBeforeCommand <= beforeCommand;
         writeEn          <= exRegWrite;
         outValid         <= exOutEn;
      end
   end

   always_ff @(posedge clk) begin
      wbResult  <= aluResult;
      writeAddr <= exWriteAddr;
   end

   assign writeData = wbResult;
   assign outData   = wbResult;

   assert property (@(posedge clk) disable iff (!rstN) !(outValid && writeEn))
      else $error("outValid and writeEn high together");

   // nothing reaches the output port before it has passed the execute stage
   assert property (@(posedge clk) $rose(rstN) |=> !outValid)
      else $error("outValid high right after reset");

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module alu (
   input  logic [`SIMPLE_DATA_W-1:0]         opA,
   input  logic [`SIMPLE_DATA_W-1:0]         opB,
   input  logic [$clog2(`SIMPLE_DATA_W)-1:0] shiftAmt,
   input  simplePkg::aluOpE                  op,
   output logic [`SIMPLE_DATA_W-1:0]         result
);
   import simplePkg::*;

   logic [2*`SIMPLE_DATA_W-1:0] rotated;

   // rotate left, upper half of the doubled word
   assign rotated = {opA, opA} << shiftAmt;

   always_comb begin
      case (op)
         aluAdd: result = opA + opB;
         aluSub: result = opA - opB;
         aluAnd: result = opA & opB;
         aluOr:  result = opA | opB;
         aluXor: result = opA ^ opB;
         aluSll: result = opA << shiftAmt;
         aluSlr: result = rotated[2*`SIMPLE_DATA_W-1:`SIMPLE_DATA_W];
         aluSrl: result = opA >> shiftAmt;
         aluSra: result = $unsigned($signed(opA) >>> shiftAmt);
         // MOV, LI, IN and OUT pass the B operand
         aluIdt: result = opB;
         default: result = '0;
      endcase
   end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module registerFile (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`SIMPLE_RADDR_W-1:0] readAddrA,
   input  logic [`SIMPLE_RADDR_W-1:0] readAddrB,
   input  logic [`SIMPLE_RADDR_W-1:0] writeAddr,
   input  logic                       writeEn,
   input  logic [`SIMPLE_DATA_W-1:0]  writeData,
   output logic [`SIMPLE_DATA_W-1:0]  readDataA,
   output logic [`SIMPLE_DATA_W-1:0]  readDataB
);

   logic [`SIMPLE_DATA_W-1:0] regs [`SIMPLE_REG_N];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `SIMPLE_REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   // plain reads, the pipeline forwards in-flight results
   assign readDataA = regs[readAddrA];
   assign readDataB = regs[readAddrB];

endmodule

/* decodeUnit.sv */
`timescale 1ns/1ps
`include "simple_defs.svh"

module decodeUnit (
   input  logic [`SIMPLE_DATA_W-1:0]  command,
   input  logic [`SIMPLE_DATA_W-1:0]  beforeCommand,
   input  logic [`SIMPLE_DATA_W-1:0]  twoBeforeCommand,
   output simplePkg::aluOpE           aluOp,
   output logic [`SIMPLE_RADDR_W-1:0] writeAddress,
   output logic                       regWrite,
   output logic                       immSel,
   output logic                       inSel,
   output logic                       outEn,
   output logic                       oneA,
   output logic                       oneB,
   output logic                       twoA,
   output logic                       twoB
);
   import simplePkg::*;

   // function field of the ALU group, bits 7:4
   typedef enum logic [3:0] {
      fnAdd = 4'b0000,
      fnSub = 4'b0001,
      fnAnd = 4'b0010,
      fnOr  = 4'b0011,
      fnXor = 4'b0100,
      fnCmp = 4'b0101,
      fnMov = 4'b0110,
      fnSll = 4'b1000,
      fnSlr = 4'b1001,
      fnSrl = 4'b1010,
      fnSra = 4'b1011,
      fnIn  = 4'b1100,
      fnOut = 4'b1101
   } aluFuncE;

   instrGroupE group;
   aluFuncE    func;

   // LI is the only immediate-group command kept
   function automatic logic isLi(input logic [`SIMPLE_DATA_W-1:0] cmd);
      return instrGroupE'(cmd[15:14]) == grpImm && cmd[13:11] == 3'b000;
   endfunction

   // does this command write Rd
   function automatic logic isWriter(input logic [`SIMPLE_DATA_W-1:0] cmd);
      aluFuncE fn;
      fn = aluFuncE'(cmd[7:4]);
      if (isLi(cmd))
         return 1'b1;
      if (instrGroupE'(cmd[15:14]) != grpAlu)
         return 1'b0;
      case (fn)
         fnAdd, fnSub, fnAnd, fnOr, fnXor, fnMov,
         fnSll, fnSlr, fnSrl, fnSra, fnIn: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   assign group = instrGroupE'(command[15:14]);
   assign func  = aluFuncE'(command[7:4]);

   always_comb begin
      aluOp = aluNon;
      inSel = 1'b0;
      outEn = 1'b0;
      if (isLi(command)) begin
         aluOp = aluIdt;
      end else if (group == grpAlu) begin
         case (func)
            fnAdd, fnSub, fnAnd, fnOr, fnXor,
            fnSll, fnSlr, fnSrl, fnSra: aluOp = aluOpE'(command[7:4]);
            // compare runs the subtract but drops the result
            fnCmp: aluOp = aluSub;
            fnMov: aluOp = aluIdt;
            fnIn: begin
               aluOp = aluIdt;
               inSel = 1'b1;
            end
            fnOut: begin
               aluOp = aluIdt;
               outEn = 1'b1;
            end
            default: aluOp = aluNon;
         endcase
      end
   end

   assign regWrite     = isWriter(command);
   assign immSel       = isLi(command);
   assign writeAddress = command[10:8];

   // A side is Rd, B side is Rs
   assign oneA = isWriter(beforeCommand) && command[10:8] == beforeCommand[10:8];
   assign twoA = isWriter(twoBeforeCommand) && command[10:8] == twoBeforeCommand[10:8];
   assign oneB = isWriter(beforeCommand) && command[13:11] == beforeCommand[10:8];
   assign twoB = isWriter(twoBeforeCommand) && command[13:11] == twoBeforeCommand[10:8];

   always_comb begin
      assert final (!regWrite || aluOp != aluNon)
         else $error("write decoded without an ALU operation");
      assert final (!(outEn && regWrite))
         else $error("OUT decoded as a register writer");
   end

endmodule

/* simplePkg.sv */
package simplePkg;

   // ALU operations
   typedef enum logic [3:0] {
      aluAdd = 4'b0000,
      aluSub = 4'b0001,
      aluAnd = 4'b0010,
      aluOr  = 4'b0011,
      aluXor = 4'b0100,
      aluSll = 4'b1000,
      aluSlr = 4'b1001,
      aluSrl = 4'b1010,
      aluSra = 4'b1011,
      aluIdt = 4'b1100,
      aluNon = 4'b1111
   } aluOpE;

   // top two command bits
   typedef enum logic [1:0] {
      grpLoad  = 2'b00,
      grpStore = 2'b01,
      grpImm   = 2'b10,
      grpAlu   = 2'b11
   } instrGroupE;

endpackage

/* simple_defs.svh */
`ifndef SIMPLE_DEFS_SVH
`define SIMPLE_DEFS_SVH

// datapath width
`define SIMPLE_DATA_W 16

// register file size and address width
`define SIMPLE_REG_N 8
`define SIMPLE_RADDR_W 3

// bubble command
// ALU group with function 1111, so no write and no output
`define SIMPLE_NOP 16'hC0F0

`endif
